/* rom_ctrl.f */
design/rom_ctrl_pkg.sv
design/rom_ctrl_mux.sv
design/rom_ctrl_rom.sv
design/rom_ctrl_checker.sv
design/rom_ctrl_top.sv
testbench/rom_ctrl_tb.sv

/* Makefile */
TOP = rom_ctrl_tb

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f rom_ctrl.f -Mdir obj_dir
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir

.PHONY: sim clean

/* testbench/rom_ctrl_input.txt */
# Columns: kind then hex arguments. W digest, R addr data, F mask,
# X restart, A alert level, Z reset
W 8f99fd90
# Clear words after the handover
R 00 80fd503c
R 01 81f9423d
R 2a aa57f556
R 3f bf02afc3
A 0
# Invalid select code for one cycle
F 1
A 1
R 13 93b066af
A 1
# Fresh reset, then a forbidden restart
Z
W 8f99fd90
A 0
X
R 00 80fd503c
A 1
R 3f bf02afc3
A 1
R 2a aa57f556
A 1

/* testbench/rom_ctrl_tb.sv */
// ##########################################################################
// Runs from the project root and reads testbench/rom_ctrl_input.txt.
// Every command starts and ends on a falling clock edge.
// ##########################################################################
`timescale 1ns/100ps

module rom_ctrl_tb import rom_ctrl_pkg::*; ();

  localparam int ClkPeriod   = 40;
  localparam int ResetCycles = 4;

  logic      clk_i;
  logic      rst_ni;
  logic      bus_req_i;
  rom_addr_t bus_addr_i;
  logic      bus_gnt_o;
  rom_data_t bus_rdata_o;
  logic      bus_rvalid_o;
  logic      restart_i;
  mubi4_t    sel_fault_i;
  rom_data_t digest_o;
  logic      done_o;
  logic      alert_o;

  // Parsed commands, kind plus up to two arguments
  logic [7:0]  cmd_kind_q[$];
  logic [31:0] cmd_a_q[$];
  logic [31:0] cmd_b_q[$];
  int          n_cmds;
  logic        cmds_loaded = 1'b0;

  rom_ctrl_top u_rom_ctrl_top (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .bus_req_i    (bus_req_i),
    .bus_addr_i   (bus_addr_i),
    .bus_gnt_o    (bus_gnt_o),
    .bus_rdata_o  (bus_rdata_o),
    .bus_rvalid_o (bus_rvalid_o),
    .restart_i    (restart_i),
    .sel_fault_i  (sel_fault_i),
    .digest_o     (digest_o),
    .done_o       (done_o),
    .alert_o      (alert_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #(ClkPeriod / 2) clk_i = ~clk_i;
  end

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    assert (actual === expected) else begin
      $display("error %0t %s expected %h actual %h", $time, name, expected, actual);
      $display("Errors found");
      $fatal(1, "value mismatch");
    end
  endtask

  task automatic apply_reset();
    rst_ni = 1'b0;
    repeat (ResetCycles) @(negedge clk_i);
    rst_ni = 1'b1;
  endtask

  // Sweep runs right after reset, a bus request meanwhile must stay unserved
  task automatic wait_done(input logic [31:0] exp_digest);
    int cycles;
    check_value("bus_gnt_o", 32'd0, 32'(bus_gnt_o));
    check_value("alert_o", 32'd0, 32'(alert_o));
    check_value("done_o", 32'd0, 32'(done_o));
    cycles     = 0;
    bus_req_i  = 1'b1;
    bus_addr_i = '0;
    while (!done_o && cycles < RomDepth + 8) begin
      @(negedge clk_i);
      cycles++;
      if (!done_o) begin
        check_value("bus_gnt_o", 32'd0, 32'(bus_gnt_o));
        check_value("bus_rvalid_o", 32'd0, 32'(bus_rvalid_o));
      end
    end
    bus_req_i = 1'b0;
    check_value("done_o", 32'd1, 32'(done_o));
    // Idle, RomDepth reads, Drain
    check_value("done_cycles", 32'(RomDepth + 2), 32'(cycles));
    check_value("digest_o", exp_digest, digest_o);
  endtask

  // One granted read, data one cycle later, then a quiet cycle
  task automatic bus_read(input logic [31:0] addr, input logic [31:0] exp_data);
    bus_req_i  = 1'b1;
    bus_addr_i = addr[RomAw-1:0];
    #(ClkPeriod / 4);
    check_value("bus_gnt_o", 32'd1, 32'(bus_gnt_o));
    @(negedge clk_i);
    bus_req_i = 1'b0;
    check_value("bus_rvalid_o", 32'd1, 32'(bus_rvalid_o));
    check_value("bus_rdata_o", exp_data, bus_rdata_o);
    @(negedge clk_i);
    check_value("bus_rvalid_o", 32'd0, 32'(bus_rvalid_o));
  endtask

  task automatic pulse_fault(input logic [31:0] mask);
    sel_fault_i = mask[3:0];
    @(negedge clk_i);
    sel_fault_i = '0;
  endtask

  // Checker leaves Done on the pulse
  task automatic pulse_restart();
    restart_i = 1'b1;
    @(negedge clk_i);
    restart_i = 1'b0;
    check_value("done_o", 32'd0, 32'(done_o));
  endtask

  initial begin
    int         fd;
    int         code;
    logic [7:0] kind;
    logic [31:0] a;
    logic [31:0] b;
    string      skip;
    rst_ni      = 1'b0;
    bus_req_i   = 1'b0;
    bus_addr_i  = '0;
    restart_i   = 1'b0;
    sel_fault_i = '0;
    fd = $fopen("testbench/rom_ctrl_input.txt", "r");
    if (fd == 0) begin
      $display("Errors found");
      $fatal(1, "cannot open the stimulus file");
    end
    code = $fscanf(fd, "%s", kind);
    while (code == 1) begin
      a = '0;
      b = '0;
      case (kind)
        "#": code = $fgets(skip, fd);
        "R": code = $fscanf(fd, "%h %h", a, b);
        "W", "F", "A": code = $fscanf(fd, "%h", a);
        default: ;
      endcase
      if (kind != "#") begin
        cmd_kind_q.push_back(kind);
        cmd_a_q.push_back(a);
        cmd_b_q.push_back(b);
      end
      code = $fscanf(fd, "%s", kind);
    end
    $fclose(fd);
    n_cmds      = cmd_kind_q.size();
    cmds_loaded = 1'b1;
    @(negedge clk_i);
    apply_reset();
    foreach (cmd_kind_q[i]) begin
      case (cmd_kind_q[i])
        "W": wait_done(cmd_a_q[i]);
        "R": bus_read(cmd_a_q[i], cmd_b_q[i]);
        "F": pulse_fault(cmd_a_q[i]);
        "X": pulse_restart();
        "A": check_value("alert_o", cmd_a_q[i], 32'(alert_o));
        "Z": apply_reset();
        default: begin
          $display("Errors found");
          $fatal(1, "unknown command in the stimulus file");
        end
      endcase
    end
    $display("No errors");
    $finish;
  end

  // Budget of one sweep plus ten cycles per command
  initial begin
    wait (cmds_loaded);
    #((RomDepth + 10 * n_cmds) * ClkPeriod);
    $display("Errors found");
    $fatal(1, "timeout, the run did not finish in time");
  end

endmodule

/* design/rom_ctrl_top.sv */
// ##########################################################################
// sel_fault_i is XORed onto the select to model a glitch. Keep it zero
// in normal use, any other value may raise the alert.
// ##########################################################################
`timescale 1ns/100ps

module rom_ctrl_top import rom_ctrl_pkg::*; (
  input  logic      clk_i,
  input  logic      rst_ni,

  input  logic      bus_req_i,
  input  rom_addr_t bus_addr_i,
  output logic      bus_gnt_o,
  output rom_data_t bus_rdata_o,
  output logic      bus_rvalid_o,

  input  logic      restart_i,
  input  mubi4_t    sel_fault_i,
  output rom_data_t digest_o,
  output logic      done_o,
  output logic      alert_o
);

  mubi4_t    sel_bus_chk;
  mubi4_t    sel_bus_mux;
  rom_addr_t chk_addr;
  logic      chk_req;
  rom_data_t chk_rdata;
  rom_req_t  rom_req;
  rom_rsp_t  rom_rsp;

  rom_ctrl_checker u_checker (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .restart_i    (restart_i),
    .chk_addr_o   (chk_addr),
    .chk_req_o    (chk_req),
    .chk_rdata_i  (chk_rdata),
    .chk_rvalid_i (rom_rsp.rvalid),
    .sel_bus_o    (sel_bus_chk),
    .digest_o     (digest_o),
    .done_o       (done_o)
  );

  rom_ctrl_rom u_rom (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .rom_req_i (rom_req),
    .rom_rsp_o (rom_rsp)
  );

  // Glitch injection point on the select wires
  assign sel_bus_mux = sel_bus_chk ^ sel_fault_i;

  rom_ctrl_mux u_mux (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .sel_bus_i    (sel_bus_mux),
    .bus_addr_i   (bus_addr_i),
    .bus_req_i    (bus_req_i),
    .bus_gnt_o    (bus_gnt_o),
    .bus_rdata_o  (bus_rdata_o),
    .bus_rvalid_o (bus_rvalid_o),
    .chk_addr_i   (chk_addr),
    .chk_req_i    (chk_req),
    .chk_rdata_o  (chk_rdata),
    .rom_req_o    (rom_req),
    .rom_rsp_i    (rom_rsp),
    .alert_o      (alert_o)
  );

endmodule

/* design/rom_ctrl_checker.sv */
// ##########################################################################
// Reads all RomDepth words once after reset and folds a digest. The
// digest is reported only. A restart sweep is not granted the ROM.
// ##########################################################################
`timescale 1ns/100ps

module rom_ctrl_checker import rom_ctrl_pkg::*; (
  input  logic      clk_i,
  input  logic      rst_ni,
  input  logic      restart_i,

  // Sweep requests towards the switch
  output rom_addr_t chk_addr_o,
  output logic      chk_req_o,
  input  rom_data_t chk_rdata_i,
  input  logic      chk_rvalid_i,

  output mubi4_t    sel_bus_o,
  output rom_data_t digest_o,
  output logic      done_o
);

  localparam rom_addr_t LastAddr = rom_addr_t'(RomDepth - 1);

  chk_state_e state_q;
  chk_state_e state_d;
  rom_addr_t  addr_q;
  rom_addr_t  addr_d;
  // Outstanding reads, at most one with a one-cycle ROM
  logic       pend_q;
  logic       fold;
  rom_data_t  digest_q;
  rom_data_t  digest_d;

  always_comb begin
    state_d   = state_q;
    addr_d    = addr_q;
    chk_req_o = 1'b0;
    unique case (state_q)
      // Start straight after reset
      Idle: begin
        state_d = Sweep;
        addr_d  = '0;
      end
      // One read per cycle, in address order
      Sweep: begin
        chk_req_o = 1'b1;
        addr_d    = addr_q + 1'b1;
        if (addr_q == LastAddr) begin
          state_d = Drain;
        end
      end
      // Response to the last read is due in this cycle
      Drain: begin
        state_d = Done;
      end
      Done: begin
        if (restart_i) begin
          state_d = Sweep;
          addr_d  = '0;
        end
      end
      default: begin
        state_d = Idle;
      end
    endcase
  end

  // Only responses to our own reads are folded
  assign fold = pend_q & chk_rvalid_i;

  always_comb begin
    digest_d = digest_q;
    if (state_q == Done && restart_i) begin
      digest_d = '0;
    end else if (fold) begin
      // Rotate left by one, then XOR in the scrambled word
      digest_d = {digest_q[RomDw-2:0], digest_q[RomDw-1]} ^ chk_rdata_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q  <= Idle;
      addr_q   <= '0;
      pend_q   <= 1'b0;
      digest_q <= '0;
    end else begin
      state_q  <= state_d;
      addr_q   <= addr_d;
      pend_q   <= chk_req_o;
      digest_q <= digest_d;
    end
  end

  assign chk_addr_o = addr_q;
  assign done_o     = (state_q == Done);
  // Hand the ROM to the bus only when the sweep is complete
  assign sel_bus_o  = done_o ? MuBi4True : MuBi4False;
  assign digest_o   = digest_q;

  a_drain_short: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (state_q == Drain) [*2] |=> (state_q != Drain));

endmodule

/* design/rom_ctrl_rom.sv */
// ##########################################################################
// Fixed-latency ROM model, every request answers in the next cycle.
// No back-pressure, a response cannot be held.
// ##########################################################################
`timescale 1ns/100ps

module rom_ctrl_rom import rom_ctrl_pkg::*; (
  input  logic     clk_i,
  input  logic     rst_ni,
  input  rom_req_t rom_req_i,
  output rom_rsp_t rom_rsp_o
);

  logic      rvalid_q;
  rom_addr_t rom_addr_q;
  rom_addr_t prince_addr_q;
  rom_data_t clr_word;

  // Valid flag is control state
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rvalid_q <= 1'b0;
    end else begin
      rvalid_q <= rom_req_i.req;
    end
  end

  // Addresses are captured every cycle
  always_ff @(posedge clk_i) begin
    rom_addr_q    <= rom_req_i.rom_addr;
    prince_addr_q <= rom_req_i.prince_addr;
  end

  // Table lookup on the registered address
  assign clr_word = rom_word(rom_addr_q);

  assign rom_rsp_o.clr_rdata = clr_word;
  // Scrambled view, keyed by the scramble address
  assign rom_rsp_o.scr_rdata = clr_word ^ rom_mask(prince_addr_q);
  assign rom_rsp_o.rvalid    = rvalid_q;

  // No response without a request in the cycle before
  a_no_spurious_rvalid: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !rom_req_i.req |=> !rom_rsp_o.rvalid);

endmodule

/* design/rom_ctrl_mux.sv */
// ##########################################################################
// One-way switch: once the select reads True the bus keeps the ROM until
// reset. The alert is sticky and is only cleared by reset.
// ##########################################################################
`timescale 1ns/100ps

module rom_ctrl_mux import rom_ctrl_pkg::*; (
  input  logic      clk_i,
  input  logic      rst_ni,

  // Select from the checker, possibly corrupted on the way
  input  mubi4_t    sel_bus_i,

  // Host bus port
  input  rom_addr_t bus_addr_i,
  input  logic      bus_req_i,
  output logic      bus_gnt_o,
  output rom_data_t bus_rdata_o,
  output logic      bus_rvalid_o,

  // Checker port
  input  rom_addr_t chk_addr_i,
  input  logic      chk_req_i,
  output rom_data_t chk_rdata_o,

  // ROM port
  output rom_req_t  rom_req_o,
  input  rom_rsp_t  rom_rsp_i,

  output logic      alert_o
);

  // Select as seen this cycle, folded with the history so it cannot go back
  mubi4_t sel_bus_d;
  // Registered select and a copy one cycle older
  mubi4_t sel_bus_q;
  mubi4_t sel_bus_qq;

  logic   sel_to_bus;
  logic   sel_invalid;
  logic   sel_reverted;
  logic   sel_q_reverted;
  logic   alert_q;

  assign sel_bus_d = mubi4_or_hi(sel_bus_q, sel_bus_i);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      sel_bus_q  <= MuBi4False;
      sel_bus_qq <= MuBi4False;
    end else begin
      sel_bus_q  <= sel_bus_d;
      sel_bus_qq <= sel_bus_q;
    end
  end

  // Corrupt code on the input or in the register
  assign sel_invalid = mubi4_test_invalid(sel_bus_i) || mubi4_test_invalid(sel_bus_q);

  // Input falls back to the checker after the handover
  assign sel_reverted = mubi4_test_true_loose(sel_bus_q) & mubi4_test_false_loose(sel_bus_i);

  // Register itself went back, only a fault can do that
  assign sel_q_reverted = mubi4_test_true_loose(sel_bus_qq) &
                          mubi4_test_false_loose(sel_bus_q);

  // Any one of the three sets the alert
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      alert_q <= 1'b0;
    end else begin
      alert_q <= alert_q | sel_invalid | sel_reverted | sel_q_reverted;
    end
  end

  assign alert_o = alert_q;

  // Bus owns the ROM from the first True cycle on
  assign sel_to_bus = mubi4_test_true_strict(sel_bus_d);

  assign bus_gnt_o   = sel_to_bus;
  assign bus_rdata_o = rom_rsp_i.clr_rdata;
  // A response belongs to the bus if the select was already True last cycle
  assign bus_rvalid_o = mubi4_test_true_strict(sel_bus_q) & rom_rsp_i.rvalid;

  assign chk_rdata_o = rom_rsp_i.scr_rdata;

  // Bus uses one address for both lookups
  assign rom_req_o.req         = sel_to_bus ? bus_req_i  : chk_req_i;
  assign rom_req_o.rom_addr    = sel_to_bus ? bus_addr_i : chk_addr_i;
  assign rom_req_o.prince_addr = sel_to_bus ? bus_addr_i : chk_addr_i;

  // Handover is final in the register
  a_sel_one_way: assert property (@(posedge clk_i) disable iff (!rst_ni)
    mubi4_test_true_strict(sel_bus_q) |=> mubi4_test_true_strict(sel_bus_q));

  // A grant leaves the registered select on the bus for the response cycle
  a_gnt_sel_true: assert property (@(posedge clk_i) disable iff (!rst_ni)
    bus_gnt_o |=> mubi4_test_true_strict(sel_bus_q));

endmodule

/* design/rom_ctrl_pkg.sv */
// ##########################################################################
// ROM is a fixed 64 x 32 table and the keystream is a fixed function.
// Neither is a real cipher, so the digest only covers the sweep order.
// ##########################################################################
package rom_ctrl_pkg;

  // Geometry
  localparam int unsigned RomAw    = 6;
  localparam int unsigned RomDw    = 32;
  localparam int unsigned RomDepth = 64;

  typedef logic [RomAw-1:0] rom_addr_t;
  typedef logic [RomDw-1:0] rom_data_t;

  // Multi-bit select, only two legal codes
  typedef logic [3:0] mubi4_t;
  localparam mubi4_t MuBi4True  = 4'h6;
  localparam mubi4_t MuBi4False = 4'h9;

  function automatic logic mubi4_test_true_strict(mubi4_t val);
    return val == MuBi4True;
  endfunction

  function automatic logic mubi4_test_invalid(mubi4_t val);
    return (val != MuBi4True) && (val != MuBi4False);
  endfunction

  // Anything but False counts as True
  function automatic logic mubi4_test_true_loose(mubi4_t val);
    return val != MuBi4False;
  endfunction

  // Anything but True counts as False
  function automatic logic mubi4_test_false_loose(mubi4_t val);
    return val != MuBi4True;
  endfunction

  // Bits set in True are ORed, the others ANDed, so True on either side wins
  function automatic mubi4_t mubi4_or_hi(mubi4_t a, mubi4_t b);
    mubi4_t res;
    for (int k = 0; k < 4; k++) begin
      res[k] = MuBi4True[k] ? (a[k] | b[k]) : (a[k] & b[k]);
    end
    return res;
  endfunction

  // Clear ROM content, a fixed shuffle of the address bits
  function automatic rom_data_t rom_word(rom_addr_t a);
    return {2'b10, a, ~a, a ^ 6'h15, {a[2:0], a[5:3]}, a ^ 6'h3c};
  endfunction

  // Keystream per scramble address
  function automatic rom_data_t rom_mask(rom_addr_t a);
    return ({26'd0, a} * 32'h0405_0607) ^ 32'h9e37_79b9;
  endfunction

  typedef struct packed {
    logic      req;
    rom_addr_t rom_addr;
    rom_addr_t prince_addr;
  } rom_req_t;

  typedef struct packed {
    rom_data_t scr_rdata;
    rom_data_t clr_rdata;
    logic      rvalid;
  } rom_rsp_t;

  typedef enum logic [1:0] {
    Idle,
    Sweep,
    Drain,
    Done
  } chk_state_e;

endpackage
